//--- common/nocPkg.sv
`default_nettype none

package nocPkg;

  localparam int lengthW = 12;
  localparam int payloadW = 16;

  typedef enum logic [2:0]
  {
    kindIdle   = 3'd0,
    kindHeader = 3'd1,
    kindBody   = 3'd2,
    kindTail   = 3'd3
  } flitKindT;

  // one flit as it sits in a FIFO or on a link
  typedef struct packed
  {
    flitKindT             kind;
    logic [lengthW-1:0]   length;  // hold budget, header only
    logic [payloadW-1:0]  payload;
  } flitT;

  // sender side of a four-phase link, ack comes back on its own wire
  typedef struct packed
  {
    logic req;
    flitT flit;
  } linkT;

endpackage

`default_nettype wire

//--- common/arbPkg.sv
`default_nettype none

package arbPkg;

  localparam int numPorts = 5;

  typedef logic [2:0] portIdxT;

  // cyclic priority order L, N, E, W, S
  localparam portIdxT portL = 3'd0;
  localparam portIdxT portN = 3'd1;
  localparam portIdxT portE = 3'd2;
  localparam portIdxT portW = 3'd3;
  localparam portIdxT portS = 3'd4;

  // one-hot grant, bit 0 is idle and bit p+1 is port p
  typedef logic [numPorts:0] grantT;

  localparam grantT grantIdle = 6'b000001;
  localparam grantT grantL    = 6'b000010;
  localparam grantT grantN    = 6'b000100;
  localparam grantT grantE    = 6'b001000;
  localparam grantT grantW    = 6'b010000;
  localparam grantT grantS    = 6'b100000;

  localparam int fifoDepth = 4;  // keep a power of two
  localparam int fifoPtrW = $clog2(fifoDepth);

endpackage

`default_nettype wire

//--- rtl/inputPort.sv
`timescale 1ns/100ps
`default_nettype none

module inputPort
(
  input  wire                clk,
  input  wire                rst,
  input  wire nocPkg::linkT  inLink,
  output logic               inAck,
  input  wire                pop,
  output logic               headValid,
  output nocPkg::flitT       headFlit
);

  nocPkg::flitT mem [arbPkg::fifoDepth];

  logic [arbPkg::fifoPtrW-1:0] wrPtr;
  logic [arbPkg::fifoPtrW-1:0] rdPtr;
  logic [arbPkg::fifoPtrW:0]   count;
  logic                        full;
  logic                        push;
  logic                        doPop;

  assign full = count[arbPkg::fifoPtrW];  // count == fifoDepth
  assign headValid = count != '0;
  assign headFlit = mem[rdPtr];

  // take a flit once per req rise, hold ack low while there is no room
  assign push = inLink.req && !inAck && !full;
  assign doPop = pop && headValid;

  // receive-side handshake
  always_ff @(posedge clk)
  begin
    if (rst)
      inAck <= 1'b0;
    else if (push)
      inAck <= 1'b1;
    else if (inAck && !inLink.req)
      inAck <= 1'b0;  // return to zero
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inLink.flit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1;
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      case ({push, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

//--- arbiter/grantTimer.sv
`timescale 1ns/100ps
`default_nettype none

module grantTimer
(
  input  wire                clk,
  input  wire                rst,
  input  wire nocPkg::flitT  headFlit,
  input  wire                granted,
  input  wire                active,
  output logic               expired
);

  logic [nocPkg::lengthW-1:0] budget;
  logic [nocPkg::lengthW-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count <= '0;
    end
    else
    begin
      // a header at the head sets the budget for the packet behind it
      if (headFlit.kind == nocPkg::kindHeader)
        budget <= headFlit.length;
      if (granted && active)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign expired = count == budget;  // zero budget expires at once

endmodule

`default_nettype wire

//--- arbiter/outputArbiter.sv
`timescale 1ns/100ps
`default_nettype none

module outputArbiter
(
  input  wire                                        clk,
  input  wire                                        rst,
  input  wire [arbPkg::numPorts-1:0]                 headValid,
  input  wire nocPkg::flitT [arbPkg::numPorts-1:0]   headFlits,
  output arbPkg::grantT                              grant
);

  wire [arbPkg::numPorts-1:0] expired;

  arbPkg::grantT   nextGrant;
  arbPkg::portIdxT owner;
  logic            ownerValid;
  logic            found;
  int              start;
  int              span;
  int              cand;

  // one hold-budget timer per port, running only for the owner
  for (genvar p = 0; p < arbPkg::numPorts; p++)
  begin : genTimer
    grantTimer timer
    (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlits[p]),
      .granted  (grant[p+1]),
      .active   (headValid[p]),
      .expired  (expired[p])
    );
  end

  assign ownerValid = !grant[0];

  always_comb
  begin
    owner = arbPkg::portL;
    for (int p = 0; p < arbPkg::numPorts; p++)
    begin
      if (grant[p+1])
        owner = arbPkg::portIdxT'(p);
    end
  end

  // owner keeps the grant until its request drops or its budget runs out.
  // After that the search starts just past the owner and skips it, so a
  // lone requester goes through idle before it is granted again.
  always_comb
  begin
    nextGrant = arbPkg::grantIdle;
    found = 1'b0;
    start = ownerValid ? int'(owner) + 1 : int'(arbPkg::portL);
    span = ownerValid ? arbPkg::numPorts - 1 : arbPkg::numPorts;
    cand = 0;
    if (ownerValid && headValid[owner] && !expired[owner])
      nextGrant = grant;
    else
    begin
      for (int i = 0; i < arbPkg::numPorts; i++)
      begin
        cand = start + i;
        if (cand >= arbPkg::numPorts)
          cand = cand - arbPkg::numPorts;  // wrap S back to L
        if (!found && i < span && headValid[cand])
        begin
          found = 1'b1;
          nextGrant = arbPkg::grantIdle << (cand + 1);
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= arbPkg::grantIdle;
    else
      grant <= nextGrant;
  end

endmodule

`default_nettype wire

//--- rtl/outputLink.sv
`timescale 1ns/100ps
`default_nettype none

module outputLink
(
  input  wire                                        clk,
  input  wire                                        rst,
  input  wire arbPkg::grantT                         grant,
  input  wire [arbPkg::numPorts-1:0]                 headValid,
  input  wire nocPkg::flitT [arbPkg::numPorts-1:0]   headFlits,
  output logic [arbPkg::numPorts-1:0]                pop,
  output nocPkg::linkT                               outLink,
  input  wire                                        outAck
);

  arbPkg::portIdxT selPort;
  logic            selValid;
  logic            take;
  logic            sendReq;
  nocPkg::flitT    sendFlit;

  // granted port index
  always_comb
  begin
    selValid = 1'b1;
    selPort = arbPkg::portL;
    case (grant)
      arbPkg::grantL: selPort = arbPkg::portL;
      arbPkg::grantN: selPort = arbPkg::portN;
      arbPkg::grantE: selPort = arbPkg::portE;
      arbPkg::grantW: selPort = arbPkg::portW;
      arbPkg::grantS: selPort = arbPkg::portS;
      default:        selValid = 1'b0;  // idle
    endcase
  end

  // sender is free only once both req and ack are back at zero
  assign take = selValid && headValid[selPort] && !sendReq && !outAck;

  always_comb
  begin
    pop = '0;
    pop[selPort] = take;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      sendReq <= 1'b0;
    else if (take)
      sendReq <= 1'b1;
    else if (sendReq && outAck)
      sendReq <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (take)
      sendFlit <= headFlits[selPort];  // stable until the next take
  end

  assign outLink = '{req: sendReq, flit: sendFlit};

endmodule

`default_nettype wire

//--- rtl/routerOutputStage.sv
`timescale 1ns/100ps
`default_nettype none

module routerOutputStage
(
  input  wire                                        clk,
  input  wire                                        rst,
  input  wire nocPkg::linkT [arbPkg::numPorts-1:0]   inLinks,
  output wire [arbPkg::numPorts-1:0]                 inAcks,
  output wire nocPkg::linkT                          outLink,
  input  wire                                        outAck
);

  wire [arbPkg::numPorts-1:0]                headValid;
  wire [arbPkg::numPorts-1:0]                pop;
  wire nocPkg::flitT [arbPkg::numPorts-1:0]  headFlits;
  wire arbPkg::grantT                        grant;

  // L, N, E, W, S in index order
  for (genvar p = 0; p < arbPkg::numPorts; p++)
  begin : genPort
    inputPort port
    (
      .clk       (clk),
      .rst       (rst),
      .inLink    (inLinks[p]),
      .inAck     (inAcks[p]),
      .pop       (pop[p]),
      .headValid (headValid[p]),
      .headFlit  (headFlits[p])
    );
  end

  outputArbiter arbiter
  (
    .clk       (clk),
    .rst       (rst),
    .headValid (headValid),
    .headFlits (headFlits),
    .grant     (grant)
  );

  outputLink link
  (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .headValid (headValid),
    .headFlits (headFlits),
    .pop       (pop),
    .outLink   (outLink),
    .outAck    (outAck)
  );

endmodule

`default_nettype wire

//--- dv/routerOutputStageTb.sv
`timescale 1ns/100ps
`default_nettype none

module routerOutputStageTb;

  localparam int waitLimit = 400;  // cycles allowed for one handshake step
  localparam int drainLimit = 4000;
  localparam int runLimit = 80000;
  localparam int maxDelay = 5;

  logic                                 clk;
  logic                                 rst;
  nocPkg::linkT [arbPkg::numPorts-1:0]  inLinks;
  wire [arbPkg::numPorts-1:0]           inAcks;
  wire nocPkg::linkT                    outLink;
  logic                                 outAck;

  nocPkg::flitT expQ [arbPkg::numPorts][$];  // scoreboard with one queue per source
  logic [11:0]  seqNum [arbPkg::numPorts];
  int           sent [arbPkg::numPorts];
  int           errors;
  int           received;
  string        testName;
  logic         stall;  // downstream withholds ack
  logic         checkRotation;
  logic         seenL;
  logic         seenS;
  logic         seenSTail;

  routerOutputStage UUT
  (
    .clk     (clk),
    .rst     (rst),
    .inLinks (inLinks),
    .inAcks  (inAcks),
    .outLink (outLink),
    .outAck  (outAck)
  );

  always #4 clk = ~clk;

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int p = 0; p < arbPkg::numPorts; p++)
      n += expQ[p].size();
    return n;
  endfunction

  function automatic int totalSent();
    int n;
    n = 0;
    for (int p = 0; p < arbPkg::numPorts; p++)
      n += sent[p];
    return n;
  endfunction

  // upstream four-phase offer of one flit
  task automatic offerFlit(input int src, input nocPkg::flitT f);
    int t;
    expQ[src].push_back(f);
    inLinks[src].flit = f;
    inLinks[src].req = 1'b1;
    t = 0;
    while (!inAcks[src] && t < waitLimit)
    begin
      tick();
      t++;
    end
    assert (inAcks[src]) else
    begin
      errors++;
      $display("%s: source %0d got no ack for its flit", testName, src);
    end
    if (inAcks[src])
      sent[src]++;
    inLinks[src].req = 1'b0;
    t = 0;
    while (inAcks[src] && t < waitLimit)
    begin
      tick();
      t++;
    end
    assert (!inAcks[src]) else
    begin
      errors++;
      $display("%s: ack of source %0d never fell", testName, src);
    end
  endtask

  task automatic sendPacket(input int src, input int bodies,
                            input logic [nocPkg::lengthW-1:0] len);
    nocPkg::flitT f;
    for (int i = 0; i < bodies + 2; i++)
    begin
      if (i == 0)
        f.kind = nocPkg::kindHeader;
      else if (i == bodies + 1)
        f.kind = nocPkg::kindTail;
      else
        f.kind = nocPkg::kindBody;
      f.length = (i == 0) ? len : '0;
      f.payload = {src[3:0], seqNum[src]};  // source on top and sequence below
      seqNum[src]++;
      offerFlit(src, f);
    end
  endtask

  task automatic sendPackets(input int src, input int count);
    for (int k = 0; k < count; k++)
      sendPacket(src, (k + src) % 4, 6);
  endtask

  task automatic checkArrival(input nocPkg::flitT f);
    int src;
    logic known;
    nocPkg::flitT exp;
    src = int'(f.payload[nocPkg::payloadW-1 -: 4]);
    known = src < arbPkg::numPorts && expQ[src].size() > 0;
    received++;
    assert (known) else
    begin
      errors++;
      $display("%s: flit %h arrived that no source sent", testName, f);
    end
    if (known)
    begin
      exp = expQ[src].pop_front();
      assert (f == exp) else
      begin
        errors++;
        $display("ERROR %s: expected %h, actual %h", testName, exp, f);
      end
      seenL |= checkRotation && src == arbPkg::portL;
      seenS |= checkRotation && src == arbPkg::portS;
      if (checkRotation && src == arbPkg::portS && f.kind == nocPkg::kindTail)
      begin
        seenSTail = 1'b1;
        assert (seenL) else
        begin
          errors++;
          $display("%s: S kept the output to its tail while L waited", testName);
        end
      end
    end
  endtask

  task automatic waitDrained();
    int t;
    t = 0;
    while (pending() != 0 && t < drainLimit)
    begin
      tick();
      t++;
    end
    assert (pending() == 0) else
    begin
      errors++;
      $display("%s: %0d flits never reached the output", testName, pending());
    end
  endtask

  // output monitor counts one arrival per req rise
  initial
  begin : monitor
    nocPkg::flitT held;
    logic prevReq;
    held = '0;
    prevReq = 1'b0;
    forever
    begin
      tick();
      if (prevReq && outLink.req)
      begin
        assert (outLink.flit == held) else
        begin
          errors++;
          $display("ERROR %s: expected %h, actual %h", testName, held, outLink.flit);
        end
      end
      if (outLink.req && !prevReq)
      begin
        held = outLink.flit;
        checkArrival(outLink.flit);
      end
      prevReq = outLink.req;
    end
  end

  // downstream agent
  initial
  begin : downstream
    int t;
    int delay;
    void'($urandom(32'h1bbc_30dc));
    forever
    begin
      tick();
      if (outLink.req && !outAck)
      begin
        t = 0;
        while (stall && t < waitLimit)
        begin
          tick();
          t++;
        end
        delay = $urandom_range(0, maxDelay);
        repeat (delay) tick();
        outAck = 1'b1;
      end
      else if (!outLink.req && outAck)
        outAck = 1'b0;
    end
  end

  initial
  begin : watchdog
    repeat (runLimit) @(posedge clk);
    $display("run stopped after %0d cycles without reaching its end", runLimit);
    $display("errors: %0d, flits sent: %0d, flits received: %0d",
             errors + 1, totalSent(), received);
    $display("** FAIL **");
    $finish;
  end

  initial
  begin : mainSeq
    int t;
    int base;
    clk = 1'b0;
    rst = 1'b1;
    inLinks = '0;
    for (int p = 0; p < arbPkg::numPorts; p++)
      inLinks[p].req = 1'b1;  // requests seen during reset must not be taken
    outAck = 1'b0;
    stall = 1'b0;
    checkRotation = 1'b0;
    seenL = 1'b0;
    seenS = 1'b0;
    seenSTail = 1'b0;
    errors = 0;
    received = 0;
    for (int p = 0; p < arbPkg::numPorts; p++)
    begin
      seqNum[p] = '0;
      sent[p] = 0;
    end
    testName = "reset";
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    inLinks = '0;
    repeat (3)
    begin
      assert ({outLink.req, inAcks} == '0) else
      begin
        errors++;
        $display("ERROR %s: expected %b, actual %b", testName, 6'b0, {outLink.req, inAcks});
      end
      tick();
    end

    testName = "single";
    sendPacket(arbPkg::portN, 3, 8);
    waitDrained();

    testName = "contention";
    fork
      sendPackets(arbPkg::portL, 3);
      sendPackets(arbPkg::portN, 3);
      sendPackets(arbPkg::portE, 3);
      sendPackets(arbPkg::portW, 3);
      sendPackets(arbPkg::portS, 3);
    join
    waitDrained();

    testName = "rotation";
    checkRotation = 1'b1;
    fork
      sendPacket(arbPkg::portS, 10, 2);  // budget of 2 cycles
      begin
        t = 0;
        while (!seenS && t < waitLimit)
        begin
          tick();
          t++;
        end
        sendPacket(arbPkg::portL, 2, 8);
      end
    join
    waitDrained();
    assert (seenSTail) else
    begin
      errors++;
      $display("%s: tail of the S packet never arrived", testName);
    end
    checkRotation = 1'b0;

    testName = "output stall";
    fork
      sendPackets(arbPkg::portN, 2);
      sendPackets(arbPkg::portW, 2);
      repeat (6)
      begin
        stall = 1'b1;
        repeat (25) tick();
        stall = 1'b0;
        repeat (5) tick();
      end
    join
    waitDrained();

    testName = "input stall";
    base = sent[arbPkg::portE];
    stall = 1'b1;
    fork
      sendPacket(arbPkg::portE, 5, 8);
      begin
        // one flit sits in the sender and the FIFO holds the rest
        t = 0;
        while (!(sent[arbPkg::portE] == base + arbPkg::fifoDepth + 1 &&
                 inLinks[arbPkg::portE].req && !inAcks[arbPkg::portE]) && t < waitLimit)
        begin
          tick();
          t++;
        end
        repeat (20)
        begin
          tick();
          assert (!inAcks[arbPkg::portE]) else
          begin
            errors++;
            $display("%s: E got an ack while its FIFO was full", testName);
          end
          assert (sent[arbPkg::portE] == base + arbPkg::fifoDepth + 1) else
          begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", testName,
                     arbPkg::fifoDepth + 1, sent[arbPkg::portE] - base);
          end
        end
        stall = 1'b0;
      end
    join
    waitDrained();

    testName = "end";
    assert (received == totalSent()) else
    begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", testName, totalSent(), received);
    end
    $display("errors: %0d, flits sent: %0d, flits received: %0d",
             errors, totalSent(), received);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
common/nocPkg.sv
common/arbPkg.sv
rtl/inputPort.sv
arbiter/grantTimer.sv
arbiter/outputArbiter.sv
rtl/outputLink.sv
rtl/routerOutputStage.sv
dv/routerOutputStageTb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and pass only if the pass message is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module routerOutputStageTb \
  -f files.f -Mdir obj_dir &&
out="$(./obj_dir/VrouterOutputStageTb)" &&
echo "$out" &&
echo "$out" | grep -qF '** PASS **' ||
{ echo "simulation did not pass"; exit 1; }
